// File: pinx_pkg.sv
/*
 * Shared definitions for the pin link between the transmit block and the
 * receive FIFO. Holds the word layout, the framing tag encoding and the
 * credit depth that both ends of the link must agree on.
 * Every RTL file and the testbench refer to these by scoped name.
 */

`default_nettype none

package pinx_pkg;

    // Width of the payload carried in each link word
    localparam int unsigned PINX_DATA_W = 64;

    // Width of the credit counter on the transmit side and of the
    // occupancy counter on the receive side
    localparam int unsigned PINX_CNT_W = 4;

    // Number of receive FIFO slots, which is also the credit count the
    // transmitter starts with after reset
    // The counter saturates at all ones, so this can never exceed 15
    localparam logic [PINX_CNT_W-1:0] PINX_CREDITS = 4'd15;

    // Index of the last FIFO slot, where the circular pointers wrap
    localparam logic [PINX_CNT_W-1:0] PINX_FIFO_LAST = PINX_CREDITS - 1'b1;

    // Framing tag carried alongside the data
    // The link never looks at it, it only travels with the word so that
    // the consumer can rebuild packet boundaries
    typedef enum logic [1:0]
    {
        // Middle beat of a multi-word packet
        TAG_DATA   = 2'b00,
        // Opening beat of a multi-word packet
        TAG_FIRST  = 2'b01,
        // Closing beat of a multi-word packet
        TAG_LAST   = 2'b10,
        // Packet that fits in one word
        TAG_SINGLE = 2'b11
    } pinx_tag_e;

    // One word as it crosses the pins, 66 bits in total
    // The tag sits in the two upper bits, the data below it
    typedef struct packed
    {
        pinx_tag_e              tag;
        logic [PINX_DATA_W-1:0] data;
    } pinx_word_t;

endpackage

`default_nettype wire

// File: pinx_tx.sv
/*
 * Transmit end of the pin link. Takes words with valid/ready and drives
 * them onto the pins behind a launch register and a two-stage output pipe.
 * A credit count limits the words in flight to the receive FIFO depth, and
 * each token pulse coming back over the pins returns one credit.
 */

`default_nettype none
`timescale 1ns/10ps

module pinx_tx
(
    input  logic                 CLK,
    input  logic                 rst_in,

    input  pinx_pkg::pinx_word_t in_word,
    input  logic                 in_valid,
    output logic                 in_ready,

    output pinx_pkg::pinx_word_t pin_word,
    output logic                 pin_valid,
    input  logic                 pin_token
);

    // Token pulses from the pins, sampled twice before use
    logic [1:0] tok_q;
    logic       tok_arrive;

    // Credits currently available, one per free slot in the receive FIFO
    logic [pinx_pkg::PINX_CNT_W-1:0] credit_cnt;
    logic                            credit_some;
    logic                            credit_full;

    // Handshake with the upstream side
    logic accept;

    // Index 0 is the launch register loaded at the accepting edge,
    // indices 1 and 2 are the output pipe, and index 2 drives the pins
    pinx_pkg::pinx_word_t word_q [3];
    logic [2:0]           valid_q;

    // The token shifts from tok_q[0] into tok_q[1], which is the one
    // the credit logic sees
    always_ff @(posedge CLK or posedge rst_in)
    begin
        if (rst_in)
        begin
            tok_q <= 2'b00;
        end
        else
        begin
            tok_q <= {tok_q[0], pin_token};
        end
    end

    assign tok_arrive  = tok_q[1];
    assign credit_some = |credit_cnt;
    assign credit_full = &credit_cnt;

    // A token arriving in this cycle can pay for a word even at zero
    // credits, so ready also looks at the token
    assign in_ready = credit_some || tok_arrive;
    assign accept   = in_valid && in_ready;

    // When a word and a token meet in the same cycle the token is spent
    // directly and the count stays put
    // A token arriving with the count saturated is dropped
    always_ff @(posedge CLK or posedge rst_in)
    begin
        if (rst_in)
        begin
            credit_cnt <= pinx_pkg::PINX_CREDITS;
        end
        else if (tok_arrive && !accept && !credit_full)
        begin
            credit_cnt <= credit_cnt + 1'b1;
        end
        else if (accept && !tok_arrive)
        begin
            credit_cnt <= credit_cnt - 1'b1;
        end
    end

    // Valid bits of the launch register and the output pipe
    always_ff @(posedge CLK or posedge rst_in)
    begin
        if (rst_in)
        begin
            valid_q <= 3'b000;
        end
        else
        begin
            valid_q <= {valid_q[1:0], accept};
        end
    end

    // Payload follows the valid bits
    // Words are loaded every cycle, only the valid bit tells them apart
    always_ff @(posedge CLK)
    begin
        word_q[0] <= in_word;
        word_q[1] <= word_q[0];
        word_q[2] <= word_q[1];
    end

    assign pin_word  = word_q[2];
    assign pin_valid = valid_q[2];

    // A word sent with no credit in hand and no token to spend would
    // wrap the count from zero to all ones
    a_credit_backed: assert property (@(posedge CLK) disable iff (rst_in)
        (credit_cnt == '0) |=> (credit_cnt != '1));

endmodule

`default_nettype wire

// File: pinx_rx_fifo.sv
/*
 * Receive end of the pin link. Registers the pin word once, then stores it
 * in a 15-entry circular FIFO whose head is offered to the consumer with
 * valid/ready. Every word the consumer takes frees a slot and sends one
 * token pulse back to the transmitter.
 */

`default_nettype none
`timescale 1ns/10ps

module pinx_rx_fifo
(
    input  logic                 CLK,
    input  logic                 rst_in,

    input  pinx_pkg::pinx_word_t pin_word,
    input  logic                 pin_valid,
    output logic                 pin_token,

    output pinx_pkg::pinx_word_t out_word,
    output logic                 out_valid,
    input  logic                 out_ready
);

    // Pin inputs after the capture register
    pinx_pkg::pinx_word_t pin_word_q;
    logic                 pin_valid_q;

    // FIFO storage, one slot per credit on the transmit side
    pinx_pkg::pinx_word_t mem [pinx_pkg::PINX_CREDITS];

    // Circular pointers and occupancy count
    logic [pinx_pkg::PINX_CNT_W-1:0] wr_ptr;
    logic [pinx_pkg::PINX_CNT_W-1:0] rd_ptr;
    logic [pinx_pkg::PINX_CNT_W-1:0] fill_cnt;

    logic wr_en;
    logic pop;

    // Steps a pointer to the next slot and wraps after the last one
    function automatic logic [pinx_pkg::PINX_CNT_W-1:0] slot_next
    (
        input logic [pinx_pkg::PINX_CNT_W-1:0] slot
    );
        if (slot == pinx_pkg::PINX_FIFO_LAST)
        begin
            return '0;
        end
        return slot + 1'b1;
    endfunction

    // Capture the pins before anything else touches them
    always_ff @(posedge CLK or posedge rst_in)
    begin
        if (rst_in)
        begin
            pin_valid_q <= 1'b0;
        end
        else
        begin
            pin_valid_q <= pin_valid;
        end
    end

    always_ff @(posedge CLK)
    begin
        pin_word_q <= pin_word;
    end

    // There is no ready on the pins, so every captured word is written
    // The credit scheme guarantees a free slot
    assign wr_en = pin_valid_q;
    assign pop   = out_valid && out_ready;

    always_ff @(posedge CLK)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= pin_word_q;
        end
    end

    // Pointer and occupancy bookkeeping
    always_ff @(posedge CLK or posedge rst_in)
    begin
        if (rst_in)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill_cnt <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= slot_next(wr_ptr);
            end
            if (pop)
            begin
                rd_ptr <= slot_next(rd_ptr);
            end
            // A write and a pop in the same cycle leave the count alone
            case ({wr_en, pop})
                2'b10:   fill_cnt <= fill_cnt + 1'b1;
                2'b01:   fill_cnt <= fill_cnt - 1'b1;
                default: fill_cnt <= fill_cnt;
            endcase
        end
    end

    // The head slot is shown directly and stays put until it is popped,
    // since writes only land behind it
    assign out_word  = mem[rd_ptr];
    assign out_valid = |fill_cnt;

    // One token per freed slot, high for the cycle after the pop
    always_ff @(posedge CLK or posedge rst_in)
    begin
        if (rst_in)
        begin
            pin_token <= 1'b0;
        end
        else
        begin
            pin_token <= pop;
        end
    end

    // A write into a full FIFO means the transmitter overspent its credits
    a_no_overflow: assert property (@(posedge CLK) disable iff (rst_in)
        wr_en |-> (fill_cnt != pinx_pkg::PINX_CREDITS));

    // A stalled head word must not change under the consumer
    a_out_stable: assert property (@(posedge CLK) disable iff (rst_in)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_word)));

endmodule

`default_nettype wire

// File: pinx_link.sv
/*
 * Complete pin link with the transmit block and the receive FIFO joined by
 * the pin wires. Words enter on the upstream valid/ready port and leave on
 * the downstream one. Both ends run on the same clock here, so the whole
 * credit loop can be simulated in one piece.
 */

`default_nettype none
`timescale 1ns/10ps

module pinx_link
(
    input  logic                 CLK,
    input  logic                 rst_in,

    // Upstream producer side
    input  pinx_pkg::pinx_word_t in_word,
    input  logic                 in_valid,
    output logic                 in_ready,

    // Downstream consumer side
    output pinx_pkg::pinx_word_t out_word,
    output logic                 out_valid,
    input  logic                 out_ready
);

    // Forward pins from transmitter to receiver
    pinx_pkg::pinx_word_t pin_word;
    logic                 pin_valid;

    // Return pin carrying one token per freed FIFO slot
    logic pin_token;

    // Transmit end with the credit counter
    pinx_tx u_pinx_tx
    (
        .CLK       (CLK),
        .rst_in    (rst_in),
        .in_word   (in_word),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .pin_word  (pin_word),
        .pin_valid (pin_valid),
        .pin_token (pin_token)
    );

    // Receive end with the FIFO and the token return
    pinx_rx_fifo u_pinx_rx_fifo
    (
        .CLK       (CLK),
        .rst_in    (rst_in),
        .pin_word  (pin_word),
        .pin_valid (pin_valid),
        .pin_token (pin_token),
        .out_word  (out_word),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// File: tb_pinx_link.sv
/*
 * Testbench for the complete pin link. Pushes random words through the
 * credit loop from a fixed-seed xorshift generator and checks every output
 * word against a reference queue. Also covers reset values, empty-path
 * latency, the credit limit under a stalled consumer and credit recovery.
 * Compile the sources from flist.f and run tb_pinx_link as the top.
 */

`default_nettype none
`timescale 1ns/10ps

module tb_pinx_link;

    localparam time CLK_PERIOD = 100ns;

    // Edges from the accepting edge until out_valid rises on an empty link
    localparam int unsigned LAT_EDGES = 4;

    // Edges from a pop until the returned token can pay for a new word
    localparam int unsigned TOKEN_EDGES = 3;

    localparam int unsigned CREDITS    = int'(pinx_pkg::PINX_CREDITS);
    localparam int unsigned RAND_WORDS = 2000;
    localparam int unsigned TAIL_WORDS = 100;

    // Random phase, the single latency word, the stall fill, the recovery
    // refill and the final random burst
    localparam int unsigned TOTAL_WORDS = RAND_WORDS + 1 + 2 * CREDITS + TAIL_WORDS;
    localparam int unsigned WATCHDOG_CYCLES = TOTAL_WORDS * 40;

    logic                 CLK;
    logic                 rst_in;
    pinx_pkg::pinx_word_t in_word;
    logic                 in_valid;
    logic                 in_ready;
    pinx_pkg::pinx_word_t out_word;
    logic                 out_valid;
    logic                 out_ready;

    // Generator state, model queues and bookkeeping
    logic [31:0]          rng_state;
    pinx_pkg::pinx_word_t exp_q [$];
    int unsigned          acc_q [$];
    int unsigned          cycle_cnt;
    int unsigned          sent_cnt;
    int unsigned          recv_cnt;

    pinx_link u_pinx_link
    (
        .CLK       (CLK),
        .rst_in    (rst_in),
        .in_word   (in_word),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_word  (out_word),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial
    begin
        CLK = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) CLK = ~CLK;
        end
    end

    // One xorshift32 step
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_next();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // True with roughly pct percent probability
    function automatic bit chance(input int unsigned pct);
        return (rand_next() % 100) < pct;
    endfunction

    function automatic pinx_pkg::pinx_word_t random_word();
        pinx_pkg::pinx_word_t w;
        logic [31:0]          r;
        r      = rand_next();
        w.tag  = pinx_pkg::pinx_tag_e'(r[1:0]);
        w.data = {rand_next(), rand_next()};
        return w;
    endfunction

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("Result: FAILED");
    endtask

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            report_fail($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
            $fatal(1);
        end
    endtask

    task automatic check_cond(input bit ok, input string why);
        assert (ok)
        else
        begin
            report_fail(why);
            $fatal(1);
        end
    endtask

    // Looks at both handshakes as they will be taken at the coming edge
    // The output is checked first, since a word accepted now cannot be
    // visible yet
    task automatic observe();
        pinx_pkg::pinx_word_t exp_w;
        int unsigned          acc_c;
        if (out_valid)
        begin
            check_cond(exp_q.size() > 0, "out_valid is high with no word outstanding");
            exp_w = exp_q[0];
            // Compared every cycle, so a stalled head word must also hold still
            check_equal("out_word.tag", out_word.tag, exp_w.tag);
            check_equal("out_word.data", out_word.data, exp_w.data);
            if (out_ready)
            begin
                acc_c = acc_q.pop_front();
                void'(exp_q.pop_front());
                // The word became visible after the edge before this sample
                check_cond((cycle_cnt - acc_c - 1) >= LAT_EDGES,
                           "a word came out faster than the link latency allows");
                recv_cnt++;
            end
        end
        if (in_valid && in_ready)
        begin
            exp_q.push_back(in_word);
            acc_q.push_back(cycle_cnt);
            sent_cnt++;
        end
    endtask

    // One clock cycle of stimulus, driven on the falling edge
    task automatic drive_cycle(input int unsigned in_pct, input int unsigned out_pct,
                               input bit send_en);
        @(negedge CLK);
        cycle_cnt++;
        in_valid  = send_en && chance(in_pct);
        in_word   = random_word();
        out_ready = chance(out_pct);
        // Let in_ready settle after the new inputs before sampling
        #1;
        observe();
    endtask

    // Runs until exactly count more words have been accepted
    task automatic run_words(input int unsigned count, input int unsigned in_pct,
                             input int unsigned out_pct);
        int unsigned goal;
        goal = sent_cnt + count;
        while (sent_cnt < goal)
        begin
            drive_cycle(in_pct, out_pct, 1'b1);
        end
    endtask

    task automatic drain(input int unsigned out_pct);
        while (exp_q.size() > 0)
        begin
            drive_cycle(0, out_pct, 1'b0);
        end
    endtask

    task automatic idle(input int unsigned cycles);
        repeat (cycles)
        begin
            drive_cycle(0, 100, 1'b0);
        end
    endtask

    initial
    begin
        int unsigned out_pct [4];
        int unsigned base;
        int unsigned start;
        bit          ready_dropped;

        out_pct   = '{90, 50, 20, 70};
        rng_state = 32'hbfd9;
        rst_in    = 1'b1;
        in_valid  = 1'b0;
        in_word   = '0;
        out_ready = 1'b0;
        cycle_cnt = 0;
        sent_cnt  = 0;
        recv_cnt  = 0;

        // Reset spans five rising edges and drops on the falling edge after them
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        rst_in = 1'b0;
        #1;
        check_cond(in_ready === 1'b1, "in_ready is not high after reset");
        check_cond(out_valid === 1'b0, "out_valid is not low after reset");

        // Random traffic with a different consumer speed in each quarter
        for (int p = 0; p < 4; p++)
        begin
            run_words(RAND_WORDS / 4, 70, out_pct[p]);
        end
        drain(100);
        idle(8);
        check_equal("recv_cnt", recv_cnt, sent_cnt);

        // One word into the idle link, consumer always ready
        @(negedge CLK);
        cycle_cnt++;
        in_valid  = 1'b1;
        in_word   = random_word();
        out_ready = 1'b1;
        #1;
        check_cond(in_ready === 1'b1, "in_ready is low on an idle link");
        observe();
        for (int k = 1; k <= LAT_EDGES + 1; k++)
        begin
            drive_cycle(0, 100, 1'b0);
            if (k <= LAT_EDGES)
            begin
                check_cond(out_valid === 1'b0, "out_valid rose before the link latency");
            end
            else
            begin
                check_cond(out_valid === 1'b1, "out_valid did not rise after the link latency");
            end
        end
        check_equal("model depth", exp_q.size(), 0);
        idle(8);

        // Stalled consumer, the producer pushes every cycle
        base          = sent_cnt;
        ready_dropped = 1'b0;
        repeat (40)
        begin
            drive_cycle(100, 0, 1'b1);
            if (!in_ready)
            begin
                ready_dropped = 1'b1;
            end
            else
            begin
                check_cond(!ready_dropped, "in_ready rose again while the consumer stalled");
            end
        end
        check_equal("accepted words", sent_cnt - base, CREDITS);
        check_cond(ready_dropped, "in_ready never went low with all credits spent");
        check_cond(out_valid === 1'b1, "out_valid dropped while words were held");

        // Consumer wakes up while the producer keeps pushing
        // At zero credits the first new word can only ride on the token
        // returned by the first pop
        base  = sent_cnt;
        start = cycle_cnt + 1;
        while (sent_cnt == base)
        begin
            drive_cycle(100, 100, 1'b1);
        end
        check_equal("token return cycles", cycle_cnt - start, TOKEN_EDGES);
        run_words(CREDITS - 1, 100, 100);
        drain(100);
        idle(8);
        check_cond(in_ready === 1'b1, "in_ready did not return high after the drain");

        run_words(TAIL_WORDS, 70, 60);
        drain(100);
        idle(4);
        check_equal("recv_cnt", recv_cnt, sent_cnt);

        $display("Words sent %0d, received %0d", sent_cnt, recv_cnt);
        $display("Result: PASSED");
        $finish;
    end

    // Bounds the run by the total word count
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_fail("Watchdog expired before all words came out of the link");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: flist.f
pinx_pkg.sv
pinx_tx.sv
pinx_rx_fifo.sv
pinx_link.sv
tb_pinx_link.sv

// File: Bender.yml
package:
  name: pinx_link

sources:
  - pinx_pkg.sv
  - pinx_tx.sv
  - pinx_rx_fifo.sv
  - pinx_link.sv
  - target: simulation
    files:
      - tb_pinx_link.sv
